//--- hw/eth_rx_pkg.sv
package eth_rx_pkg;

    localparam int num_lanes = 4;
    localparam int lane_w = $clog2(num_lanes);
    localparam int mac_w = 48;
    localparam int cnt_w = 16;
    localparam int kind_w = 2;

    // ethertype per lane. entry 0 is the lowest word.
    localparam logic [num_lanes-1:0][15:0] lane_types = {
        16'h88cc,
        16'h86dd,
        16'h0806,
        16'h0800
    };

    localparam logic [15:0] hdr_bytes = 16'd14;
    localparam logic [15:0] min_payload = 16'd46;
    localparam logic [15:0] type_len_min_ethertype = 16'h0600;

    localparam logic [kind_w-1:0] kind_lane = 2'd0;
    localparam logic [kind_w-1:0] kind_unknown = 2'd1;
    localparam logic [kind_w-1:0] kind_length = 2'd2;

    // parser states.
    localparam logic [2:0] st_wait = 3'd0;
    localparam logic [2:0] st_dst = 3'd1;
    localparam logic [2:0] st_src = 3'd2;
    localparam logic [2:0] st_type = 3'd3;
    localparam logic [2:0] st_payload = 3'd4;
    localparam logic [2:0] st_rest = 3'd5;
    localparam logic [2:0] st_done = 3'd6;

    typedef union packed {
        logic [15:0] ethertype;
        struct packed {
            logic [4:0]  rsvd;
            logic [10:0] len;    // 802.3 length when below 16'h0600.
        } length;
    } type_len_u;

endpackage

//--- hw/rx_frame_if.sv
interface rx_frame_if import eth_rx_pkg::*;;

    logic             hdr_valid;    // pulses once the header is complete.
    logic [mac_w-1:0] dst_mac;
    logic [mac_w-1:0] src_mac;
    type_len_u        type_len;
    logic             beat_valid;
    logic [7:0]       beat_data;
    logic             beat_last;

    modport src (
        output hdr_valid, dst_mac, src_mac, type_len,
        output beat_valid, beat_data, beat_last
    );

    modport lane (
        input hdr_valid, type_len,
        input beat_valid, beat_data, beat_last
    );

    // collector only needs the captured header.
    modport sink (
        input dst_mac, src_mac, type_len
    );

endinterface

//--- hw/lane_res_if.sv
interface lane_res_if import eth_rx_pkg::*;;

    logic             done;    // held until ack.
    logic             hit;
    logic [cnt_w-1:0] bytes;
    logic [cnt_w-1:0] sum;
    logic             ack;

    modport lane (
        output done, hit, bytes, sum,
        input  ack
    );

    modport sink (
        input  done, hit, bytes, sum,
        output ack
    );

endinterface

//--- hw/eth_hdr_parser.sv
module eth_hdr_parser import eth_rx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rxd,
    input  logic        fs,
    input  logic [15:0] data_len,
    input  logic        frame_ack,
    output logic        fd,
    rx_frame_if.src     frm
);

    logic [2:0]  state;
    logic [2:0]  byte_cnt;
    logic [15:0] pay_len;
    logic [15:0] pay_cnt;
    logic        pay_end;
    logic [15:0] pay_len_next;

    assign pay_end = (pay_cnt == pay_len - 16'd1);

    // short frames are padded up to the minimum payload.
    assign pay_len_next = (data_len < hdr_bytes + min_payload) ? min_payload
                                                               : data_len - hdr_bytes;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= st_wait;
            byte_cnt       <= '0;
            pay_cnt        <= '0;
            fd             <= 1'b0;
            frm.hdr_valid  <= 1'b0;
            frm.beat_valid <= 1'b0;
            frm.beat_last  <= 1'b0;
        end else begin
            frm.hdr_valid  <= 1'b0;
            frm.beat_valid <= 1'b0;
            frm.beat_last  <= 1'b0;
            case (state)
                st_wait: begin
                    if (fs) begin    // dst byte 0 arrives with fs.
                        byte_cnt <= 3'd1;
                        state    <= st_dst;
                    end
                end
                st_dst: begin
                    if (byte_cnt == 3'd5) begin
                        byte_cnt <= '0;
                        state    <= st_src;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                st_src: begin
                    if (byte_cnt == 3'd5) begin
                        byte_cnt <= '0;
                        state    <= st_type;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                st_type: begin
                    if (byte_cnt == 3'd1) begin
                        frm.hdr_valid <= 1'b1;
                        pay_cnt       <= '0;
                        state         <= st_payload;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                st_payload: begin
                    frm.beat_valid <= 1'b1;
                    frm.beat_last  <= pay_end;
                    pay_cnt        <= pay_cnt + 16'd1;
                    if (pay_end) begin
                        state <= st_rest;
                    end
                end
                st_rest: begin
                    if (frame_ack) begin    // result taken by the collector.
                        fd    <= 1'b1;
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (!fs) begin
                        fd    <= 1'b0;
                        state <= st_wait;
                    end
                end
                default: state <= st_wait;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_wait: begin
                if (fs) begin
                    frm.dst_mac <= {frm.dst_mac[mac_w-9:0], rxd};
                end
            end
            st_dst: frm.dst_mac <= {frm.dst_mac[mac_w-9:0], rxd};    // msb first.
            st_src: frm.src_mac <= {frm.src_mac[mac_w-9:0], rxd};
            st_type: begin
                frm.type_len.ethertype <= {frm.type_len.ethertype[7:0], rxd};
                if (byte_cnt == 3'd1) begin
                    pay_len <= pay_len_next;
                end
            end
            st_payload: frm.beat_data <= rxd;
            default: ;
        endcase
    end

endmodule

//--- hw/type_lane.sv
module type_lane import eth_rx_pkg::*; #(
    parameter int lane = 0
) (
    input  logic     clk,
    input  logic     rst,
    rx_frame_if.lane frm,
    lane_res_if.lane res
);

    logic match;

    // the boundary check keeps an 802.3 length from ever matching.
    assign match = (frm.type_len.ethertype >= type_len_min_ethertype) &&
                   (frm.type_len.ethertype == lane_types[lane]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res.done <= 1'b0;
            res.hit  <= 1'b0;
        end else if (frm.hdr_valid) begin
            res.done <= 1'b0;
            res.hit  <= match;
        end else if (frm.beat_valid && frm.beat_last) begin
            res.done <= 1'b1;
        end else if (res.ack) begin
            res.done <= 1'b0;
        end
    end

    // byte count and wrapping 16-bit sum.
    always_ff @(posedge clk) begin
        if (frm.hdr_valid) begin
            res.bytes <= '0;
            res.sum   <= '0;
        end else if (frm.beat_valid) begin
            res.bytes <= res.bytes + 16'd1;
            res.sum   <= res.sum + {8'h00, frm.beat_data};
        end
    end

endmodule

//--- hw/lane_collector.sv
module lane_collector import eth_rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              res_ready,
    output logic              frame_ack,
    output logic              res_valid,
    output logic [kind_w-1:0] res_kind,
    output logic [lane_w-1:0] res_lane,
    output logic [mac_w-1:0]  res_dst,
    output logic [mac_w-1:0]  res_src,
    output type_len_u         res_type_len,
    output logic [cnt_w-1:0]  res_bytes,
    output logic [cnt_w-1:0]  res_sum,
    rx_frame_if.sink          frm,
    lane_res_if.sink          lanes [num_lanes]
);

    logic [num_lanes-1:0] done_v;
    logic [num_lanes-1:0] hit_v;
    logic                 ack_r;
    logic                 load;
    logic [lane_w-1:0]    hit_lane;
    logic [kind_w-1:0]    kind;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign done_v[i]   = lanes[i].done;
        assign hit_v[i]    = lanes[i].hit;
        assign lanes[i].ack = ack_r;
    end

    // lanes still show done during the ack cycle.
    assign load      = (&done_v) && !ack_r && (!res_valid || res_ready);
    assign frame_ack = ack_r;

    always_comb begin
        hit_lane = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (hit_v[i]) begin
                hit_lane = lane_w'(i);
            end
        end
        if (frm.type_len.ethertype < type_len_min_ethertype) begin
            kind = kind_length;
        end else if (|hit_v) begin
            kind = kind_lane;
        end else begin
            kind = kind_unknown;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
            ack_r     <= 1'b0;
        end else begin
            ack_r <= load;
            if (load) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_kind     <= kind;
            res_lane     <= hit_lane;
            res_dst      <= frm.dst_mac;
            res_src      <= frm.src_mac;
            res_type_len <= frm.type_len;
            res_bytes    <= lanes[0].bytes;    // all lanes see the same stream.
            res_sum      <= lanes[0].sum;
        end
    end

endmodule

//--- hw/eth_rx_top.sv
module eth_rx_top import eth_rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        rxd,
    input  logic              fs,
    input  logic [15:0]       data_len,
    input  logic              res_ready,
    output logic              fd,
    output logic              res_valid,
    output logic [kind_w-1:0] res_kind,
    output logic [lane_w-1:0] res_lane,
    output logic [mac_w-1:0]  res_dst,
    output logic [mac_w-1:0]  res_src,
    output type_len_u         res_type_len,
    output logic [cnt_w-1:0]  res_bytes,
    output logic [cnt_w-1:0]  res_sum
);

    logic frame_ack;

    rx_frame_if frm ();
    lane_res_if lres [num_lanes] ();

    eth_hdr_parser eth_hdr_parser_inst (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .fs        (fs),
        .data_len  (data_len),
        .frame_ack (frame_ack),
        .fd        (fd),
        .frm       (frm.src)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        type_lane #(
            .lane (i)
        ) type_lane_inst (
            .clk (clk),
            .rst (rst),
            .frm (frm.lane),
            .res (lres[i].lane)
        );
    end

    lane_collector lane_collector_inst (
        .clk          (clk),
        .rst          (rst),
        .res_ready    (res_ready),
        .frame_ack    (frame_ack),
        .res_valid    (res_valid),
        .res_kind     (res_kind),
        .res_lane     (res_lane),
        .res_dst      (res_dst),
        .res_src      (res_src),
        .res_type_len (res_type_len),
        .res_bytes    (res_bytes),
        .res_sum      (res_sum),
        .frm          (frm.sink),
        .lanes        (lres)
    );

endmodule

//--- sim/eth_rx_asserts.sv
module eth_rx_asserts import eth_rx_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              fs,
    input logic              fd,
    input logic              res_valid,
    input logic              res_ready,
    input logic [kind_w-1:0] res_kind,
    input logic [lane_w-1:0] res_lane,
    input logic [mac_w-1:0]  res_dst,
    input logic [mac_w-1:0]  res_src,
    input type_len_u         res_type_len,
    input logic [cnt_w-1:0]  res_bytes,
    input logic [cnt_w-1:0]  res_sum
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // a stalled result keeps every field.
    res_hold_a: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_kind) && $stable(res_lane) &&
            $stable(res_dst) && $stable(res_src) && $stable(res_type_len) &&
            $stable(res_bytes) && $stable(res_sum))
        else begin
            $error("result changed while stalled");
            fail_cnt++;
        end

    fd_drop_a: assert property (@(posedge clk) disable iff (rst) fd && !fs |=> !fd)
        else begin
            $error("fd held after fs fell");
            fail_cnt++;
        end

    fd_reset_a: assert property (@(posedge clk) rst |-> !fd)
        else begin
            $error("fd high during reset");
            fail_cnt++;
        end

endmodule

bind eth_rx_top eth_rx_asserts eth_rx_asserts_inst (
    .clk          (clk),
    .rst          (rst),
    .fs           (fs),
    .fd           (fd),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res_kind     (res_kind),
    .res_lane     (res_lane),
    .res_dst      (res_dst),
    .res_src      (res_src),
    .res_type_len (res_type_len),
    .res_bytes    (res_bytes),
    .res_sum      (res_sum)
);

//--- sim/eth_rx_tb.sv
module eth_rx_tb import eth_rx_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_frames = 40;

    typedef struct packed {
        logic [kind_w-1:0] kind;
        logic [lane_w-1:0] lane;
        logic [mac_w-1:0]  dst;
        logic [mac_w-1:0]  src;
        type_len_u         type_len;
        logic [cnt_w-1:0]  bytes;
        logic [cnt_w-1:0]  sum;
    } exp_t;

    logic              clk;
    logic              rst;
    logic [7:0]        rxd;
    logic              fs;
    logic [15:0]       data_len;
    logic              res_ready;
    logic              fd;
    logic              res_valid;
    logic [kind_w-1:0] res_kind;
    logic [lane_w-1:0] res_lane;
    logic [mac_w-1:0]  res_dst;
    logic [mac_w-1:0]  res_src;
    type_len_u         res_type_len;
    logic [cnt_w-1:0]  res_bytes;
    logic [cnt_w-1:0]  res_sum;

    logic [31:0] gen_state;
    logic [31:0] rdy_state;
    logic [7:0]  pay_buf [128];
    logic [15:0] len_arr [num_frames];
    exp_t        exp_q [$];
    exp_t        cur;
    int          mism_errs;
    int          other_errs;
    int          results_seen;
    int          cycle_cnt;
    int          limit_cycles;

    eth_rx_top eth_rx_top_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        gen_state = xorshift(gen_state);
        return gen_state;
    endfunction

    // short frames are padded on the wire to the minimum payload.
    function automatic logic [15:0] payload_len(input logic [15:0] len);
        return (len < 16'd60) ? 16'd46 : len - 16'd14;
    endfunction

    function automatic exp_t ref_result(input logic [15:0] len, input logic [47:0] dst,
                                        input logic [47:0] src, input type_len_u tl);
        exp_t r;
        int   i;
        r.bytes = payload_len(len);
        r.sum = '0;
        for (i = 0; i < r.bytes; i++) begin
            r.sum = r.sum + {8'h00, pay_buf[i]};
        end
        r.dst = dst;
        r.src = src;
        r.type_len = tl;
        r.lane = '0;
        if (tl.ethertype < 16'h0600) begin
            r.kind = kind_length;
        end else begin
            r.kind = kind_unknown;
            for (i = 0; i < num_lanes; i++) begin
                if (tl.ethertype == lane_types[i]) begin
                    r.kind = kind_lane;
                    r.lane = lane_w'(i);
                end
            end
        end
        return r;
    endfunction

    task automatic check_mac(input string name, input logic [47:0] got, input logic [47:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            mism_errs++;
        end
    endtask

    task automatic check_type(input string name, input type_len_u got, input type_len_u exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name,
                     got.ethertype, exp.ethertype);
            mism_errs++;
        end
    endtask

    task automatic check_kind(input string name, input logic [kind_w-1:0] got,
                              input logic [kind_w-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mism_errs++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mism_errs++;
        end
    endtask

    task automatic end_run();
        int assert_errs;
        assert_errs = eth_rx_top_inst.eth_rx_asserts_inst.fail_cnt;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 mism_errs, other_errs, assert_errs);
        if (mism_errs + other_errs + assert_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic send_frame(input logic [15:0] len, input int cat);
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [47:0] dst;
        logic [47:0] src;
        type_len_u   tl;
        logic [7:0]  hdr [14];
        logic [15:0] plen;
        int          i;
        r_hi = next_rand();
        r_lo = next_rand();
        dst = {r_hi[15:0], r_lo};
        r_hi = next_rand();
        r_lo = next_rand();
        src = {r_hi[15:0], r_lo};
        r_lo = next_rand();
        if (cat < num_lanes) begin
            tl.ethertype = lane_types[cat];
        end else if (cat == num_lanes) begin
            tl.ethertype = {4'h9, r_lo[11:0]};    // no lane uses 0x9xxx.
        end else begin
            tl.ethertype = r_lo[15:0] % 16'h0600;
        end
        plen = payload_len(len);
        for (i = 0; i < plen; i++) begin
            r_lo = next_rand();
            pay_buf[i] = r_lo[7:0];
        end
        for (i = 0; i < 6; i++) begin
            hdr[i] = dst[47 - 8 * i -: 8];    // msb first.
            hdr[6 + i] = src[47 - 8 * i -: 8];
        end
        hdr[12] = tl.ethertype[15:8];
        hdr[13] = tl.ethertype[7:0];
        exp_q.push_back(ref_result(len, dst, src, tl));

        @(posedge clk);
        fs <= 1'b1;
        data_len <= len;
        rxd <= hdr[0];
        for (i = 1; i < 14; i++) begin
            @(posedge clk);
            rxd <= hdr[i];
        end
        for (i = 0; i < plen; i++) begin
            @(posedge clk);
            rxd <= pay_buf[i];
        end
        do @(posedge clk); while (!fd);
        fs <= 1'b0;
        rxd <= 8'h00;
        do @(posedge clk); while (fd);
    endtask

    // consumer with random back-pressure.
    always @(posedge clk) begin
        rdy_state = xorshift(rdy_state);
        res_ready <= (rdy_state[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        if (!rst && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("result accepted at %0t with no frame outstanding", $time);
                other_errs++;
            end else begin
                cur = exp_q.pop_front();
                check_kind("kind", res_kind, cur.kind);
                if (cur.kind == kind_lane) begin
                    check_count("lane", 16'(res_lane), 16'(cur.lane));
                end
                if (cur.kind == kind_length) begin
                    check_count("length", 16'(res_type_len.length.len),
                                16'(cur.type_len.length.len));
                end
                check_mac("dst", res_dst, cur.dst);
                check_mac("src", res_src, cur.src);
                check_type("type_len", res_type_len, cur.type_len);
                check_count("bytes", res_bytes, cur.bytes);
                check_count("sum", res_sum, cur.sum);
            end
            results_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= limit_cycles) begin
            $display("timeout: results missing (%0d of %0d received)", results_seen, num_frames);
            other_errs++;
            end_run();
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fs = 1'b0;
        rxd = 8'h00;
        data_len = 16'd0;
        res_ready = 1'b0;
        gen_state = 32'hd2db4a72;
        rdy_state = 32'hd2db4a72;
        mism_errs = 0;
        other_errs = 0;
        results_seen = 0;
        cycle_cnt = 0;
        limit_cycles = 10;
        for (int f = 0; f < num_frames; f++) begin
            len_arr[f] = 16'd40 + 16'(next_rand() % 81);
            limit_cycles += 14 + payload_len(len_arr[f]) + 20;    // wire bytes plus slack.
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // the first six frames cover every lane, an unknown type and a length.
        for (int f = 0; f < num_frames; f++) begin
            send_frame(len_arr[f], (f < 6) ? f : int'(next_rand() % 6));
        end
        wait (results_seen == num_frames);
        repeat (10) @(posedge clk);
        if (results_seen != num_frames || exp_q.size() != 0) begin
            $display("result count wrong: %0d received for %0d frames", results_seen, num_frames);
            other_errs++;
        end
        end_run();
    end

endmodule

//--- sim.f
hw/eth_rx_pkg.sv
hw/rx_frame_if.sv
hw/lane_res_if.sv
hw/eth_hdr_parser.sv
hw/type_lane.sv
hw/lane_collector.sv
hw/eth_rx_top.sv
sim/eth_rx_asserts.sv
sim/eth_rx_tb.sv
